//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// SRAM word address and data word widths
	localparam int ADDR_W = 18;
	localparam int DATA_W = 16;

	// Requesters on the SRAM bus, listed from highest priority down
	typedef enum logic [1:0] {
		PORT_BOOT  = 2'd0,
		PORT_EXE   = 2'd1,
		PORT_FETCH = 2'd2
	} port_id_e;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} mem_op_e;

endpackage

`default_nettype wire

//--- source/boot_pkg.sv
`default_nettype none

package boot_pkg;

	localparam int FLASH_AW = 22;

	// Image length word, image words follow right after it
	localparam logic [FLASH_AW-1:0] LEN_WORD_ADDR = '0;

	typedef enum logic [1:0] {
		BOOT_LEN,
		BOOT_READ,
		BOOT_WRITE,
		BOOT_DONE
	} boot_state_e;

endpackage

`default_nettype wire

//--- source/sram_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module sram_ctrl (
	input  wire                              raw_clk,
	input  wire                              rst_n,
	input  wire                              grant_valid,
	input  wire mem_pkg::mem_op_e            grant_op,
	input  wire [mem_pkg::ADDR_W-1:0]        grant_addr,
	input  wire [mem_pkg::DATA_W-1:0]        grant_wdata,
	input  wire mem_pkg::port_id_e           grant_port,
	output logic                             ready,
	output logic                             done_valid,
	output mem_pkg::port_id_e                done_port,
	output logic [mem_pkg::DATA_W-1:0]       done_rdata,
	output logic [mem_pkg::ADDR_W-1:0]       ram_addr,
	output logic [mem_pkg::DATA_W-1:0]       ram_wdata,
	output logic                             ram_en,
	output logic                             ram_oe,
	output logic                             ram_we,
	input  wire [mem_pkg::DATA_W-1:0]        ram_rdata
);

	// Idle, then strobe cycle, then release cycle
	typedef enum logic [1:0] {
		ACC_IDLE,
		ACC_STROBE,
		ACC_RELEASE
	} acc_state_e;

	acc_state_e state;

	assign ready = (state == ACC_IDLE);

	always_ff @(posedge raw_clk) begin
		if (!rst_n) begin
			state <= ACC_IDLE;
			ram_en <= 1'b0;
			ram_oe <= 1'b0;
			ram_we <= 1'b0;
			done_valid <= 1'b0;
		end else begin
			done_valid <= 1'b0;
			case (state)
				ACC_IDLE: begin
					if (grant_valid && ready) begin
						state <= ACC_STROBE;
						ram_en <= 1'b1;
						// Only one of the two strobes per access
						ram_oe <= (grant_op == mem_pkg::OP_READ);
						ram_we <= (grant_op == mem_pkg::OP_WRITE);
					end
				end
				ACC_STROBE: begin
					state <= ACC_RELEASE;
					ram_en <= 1'b0;
					ram_oe <= 1'b0;
					ram_we <= 1'b0;
					done_valid <= ram_oe;
				end
				default: state <= ACC_IDLE;
			endcase
		end
	end

	always_ff @(posedge raw_clk) begin
		if (grant_valid && ready) begin
			ram_addr <= grant_addr;
			ram_wdata <= grant_wdata;
			done_port <= grant_port;
		end
		// Read data is stable by the end of the strobe cycle
		if (state == ACC_STROBE)
			done_rdata <= ram_rdata;
	end

endmodule

`default_nettype wire

//--- source/ram_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module ram_arbiter #(
	parameter int PORT_CREDITS = 2
) (
	input  wire                              raw_clk,
	input  wire                              rst_n,
	input  wire                              boot_req,
	input  wire mem_pkg::mem_op_e            boot_op,
	input  wire [mem_pkg::ADDR_W-1:0]        boot_addr,
	input  wire [mem_pkg::DATA_W-1:0]        boot_wdata,
	output logic                             boot_credit,
	output logic                             boot_rvalid,
	output logic [mem_pkg::DATA_W-1:0]       boot_rdata,
	input  wire                              exe_req,
	input  wire mem_pkg::mem_op_e            exe_op,
	input  wire [mem_pkg::ADDR_W-1:0]        exe_addr,
	input  wire [mem_pkg::DATA_W-1:0]        exe_wdata,
	output logic                             exe_credit,
	output logic                             exe_rvalid,
	output logic [mem_pkg::DATA_W-1:0]       exe_rdata,
	input  wire                              fetch_req,
	input  wire mem_pkg::mem_op_e            fetch_op,
	input  wire [mem_pkg::ADDR_W-1:0]        fetch_addr,
	input  wire [mem_pkg::DATA_W-1:0]        fetch_wdata,
	output logic                             fetch_credit,
	output logic                             fetch_rvalid,
	output logic [mem_pkg::DATA_W-1:0]       fetch_rdata,
	output logic                             grant_valid,
	output mem_pkg::mem_op_e                 grant_op,
	output logic [mem_pkg::ADDR_W-1:0]       grant_addr,
	output logic [mem_pkg::DATA_W-1:0]       grant_wdata,
	output mem_pkg::port_id_e                grant_port,
	input  wire                              ready,
	input  wire                              done_valid,
	input  wire mem_pkg::port_id_e           done_port,
	input  wire [mem_pkg::DATA_W-1:0]        done_rdata
);

	localparam int NPORT = 3;
	localparam int PTR_W = (PORT_CREDITS > 1) ? $clog2(PORT_CREDITS) : 1;
	localparam int CNT_W = $clog2(PORT_CREDITS + 1);

	logic                       req_v [NPORT];
	mem_pkg::mem_op_e           op_v [NPORT];
	logic [mem_pkg::ADDR_W-1:0] addr_v [NPORT];
	logic [mem_pkg::DATA_W-1:0] wdata_v [NPORT];
	logic [CNT_W-1:0]           q_count [NPORT];
	mem_pkg::mem_op_e           head_op [NPORT];
	logic [mem_pkg::ADDR_W-1:0] head_addr [NPORT];
	logic [mem_pkg::DATA_W-1:0] head_wdata [NPORT];
	logic                       pop [NPORT];
	logic                       rvalid_q [NPORT];
	logic [mem_pkg::DATA_W-1:0] rdata_q;
	logic                       any_pending;

	// Index order follows port_id_e
	assign req_v = '{boot_req, exe_req, fetch_req};
	assign op_v = '{boot_op, exe_op, fetch_op};
	assign addr_v = '{boot_addr, exe_addr, fetch_addr};
	assign wdata_v = '{boot_wdata, exe_wdata, fetch_wdata};

	for (genvar p = 0; p < NPORT; p++) begin : g_queue
		mem_pkg::mem_op_e           q_op [PORT_CREDITS];
		logic [mem_pkg::ADDR_W-1:0] q_addr [PORT_CREDITS];
		logic [mem_pkg::DATA_W-1:0] q_wdata [PORT_CREDITS];
		logic [PTR_W-1:0]           wr_ptr;
		logic [PTR_W-1:0]           rd_ptr;

		assign pop[p] = grant_valid && (grant_port == mem_pkg::port_id_e'(p));

		always_ff @(posedge raw_clk) begin
			if (!rst_n) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				q_count[p] <= '0;
			end else begin
				if (req_v[p])
					wr_ptr <= (wr_ptr == PTR_W'(PORT_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
				if (pop[p])
					rd_ptr <= (rd_ptr == PTR_W'(PORT_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
				q_count[p] <= q_count[p] + CNT_W'(req_v[p]) - CNT_W'(pop[p]);
			end
		end

		always_ff @(posedge raw_clk) begin
			if (req_v[p]) begin
				q_op[wr_ptr] <= op_v[p];
				q_addr[wr_ptr] <= addr_v[p];
				q_wdata[wr_ptr] <= wdata_v[p];
			end
		end

		assign head_op[p] = q_op[rd_ptr];
		assign head_addr[p] = q_addr[rd_ptr];
		assign head_wdata[p] = q_wdata[rd_ptr];
	end

	// Fixed priority, lowest index wins
	always_comb begin
		grant_port = mem_pkg::PORT_BOOT;
		any_pending = 1'b0;
		for (int p = NPORT - 1; p >= 0; p--) begin
			if (q_count[p] != '0) begin
				grant_port = mem_pkg::port_id_e'(p);
				any_pending = 1'b1;
			end
		end
	end

	assign grant_valid = any_pending && ready;
	assign grant_op = head_op[grant_port];
	assign grant_addr = head_addr[grant_port];
	assign grant_wdata = head_wdata[grant_port];

	// A slot frees up as soon as its entry is granted
	assign boot_credit = pop[mem_pkg::PORT_BOOT];
	assign exe_credit = pop[mem_pkg::PORT_EXE];
	assign fetch_credit = pop[mem_pkg::PORT_FETCH];

	always_ff @(posedge raw_clk) begin
		if (!rst_n) begin
			for (int p = 0; p < NPORT; p++)
				rvalid_q[p] <= 1'b0;
		end else begin
			for (int p = 0; p < NPORT; p++)
				rvalid_q[p] <= done_valid && (done_port == mem_pkg::port_id_e'(p));
		end
	end

	always_ff @(posedge raw_clk) begin
		if (done_valid)
			rdata_q <= done_rdata;
	end

	assign boot_rvalid = rvalid_q[mem_pkg::PORT_BOOT];
	assign exe_rvalid = rvalid_q[mem_pkg::PORT_EXE];
	assign fetch_rvalid = rvalid_q[mem_pkg::PORT_FETCH];
	assign boot_rdata = rdata_q;
	assign exe_rdata = rdata_q;
	assign fetch_rdata = rdata_q;

endmodule

`default_nettype wire

//--- source/bootloader.sv
`timescale 1ns/10ps
`default_nettype none

module bootloader #(
	parameter int PORT_CREDITS = 2
) (
	input  wire                              raw_clk,
	input  wire                              rst_n,
	output logic [boot_pkg::FLASH_AW-1:0]    flash_addr,
	output logic                             flash_rd,
	input  wire                              flash_ready,
	input  wire [mem_pkg::DATA_W-1:0]        flash_rdata,
	input  wire                              credit,
	output logic                             req,
	output mem_pkg::mem_op_e                 op,
	output logic [mem_pkg::ADDR_W-1:0]       addr,
	output logic [mem_pkg::DATA_W-1:0]       wdata,
	output logic                             boot_done
);

	localparam int CNT_W = $clog2(PORT_CREDITS + 1);

	boot_pkg::boot_state_e      state;
	logic [mem_pkg::DATA_W-1:0] len;
	logic [mem_pkg::DATA_W-1:0] idx;
	logic [mem_pkg::DATA_W-1:0] word;
	logic [CNT_W-1:0]           credits;
	logic                       rd_wait;
	logic                       send;

	assign op = mem_pkg::OP_WRITE;
	assign send = (state == boot_pkg::BOOT_WRITE) && (credits != '0);

	// Word n of the image sits one past the length word
	assign flash_addr = (state == boot_pkg::BOOT_LEN) ? boot_pkg::LEN_WORD_ADDR :
		boot_pkg::LEN_WORD_ADDR + 1'b1 +
		{{(boot_pkg::FLASH_AW - mem_pkg::DATA_W){1'b0}}, idx};

	always_ff @(posedge raw_clk) begin
		if (!rst_n) begin
			state <= boot_pkg::BOOT_LEN;
			idx <= '0;
			credits <= CNT_W'(PORT_CREDITS);
			rd_wait <= 1'b0;
			flash_rd <= 1'b0;
			req <= 1'b0;
			boot_done <= 1'b0;
		end else begin
			flash_rd <= 1'b0;
			req <= send;
			credits <= credits - CNT_W'(send) + CNT_W'(credit);
			case (state)
				boot_pkg::BOOT_LEN, boot_pkg::BOOT_READ: begin
					if (!rd_wait) begin
						flash_rd <= 1'b1;
						rd_wait <= 1'b1;
					end else if (flash_ready) begin
						rd_wait <= 1'b0;
						if (state == boot_pkg::BOOT_READ)
							state <= boot_pkg::BOOT_WRITE;
						else if (flash_rdata == '0)
							state <= boot_pkg::BOOT_DONE;
						else
							state <= boot_pkg::BOOT_READ;
					end
				end
				boot_pkg::BOOT_WRITE: begin
					if (send) begin
						idx <= idx + 1'b1;
						if (idx + 1'b1 == len)
							state <= boot_pkg::BOOT_DONE;
						else
							state <= boot_pkg::BOOT_READ;
					end
				end
				default: begin
					// Finished once every write has left the arbiter queue
					if (credits + CNT_W'(credit) == PORT_CREDITS)
						boot_done <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge raw_clk) begin
		if (rd_wait && flash_ready) begin
			if (state == boot_pkg::BOOT_LEN)
				len <= flash_rdata;
			else
				word <= flash_rdata;
		end
		if (send) begin
			addr <= {{(mem_pkg::ADDR_W - mem_pkg::DATA_W){1'b0}}, idx};
			wdata <= word;
		end
	end

endmodule

`default_nettype wire

//--- source/inst_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module inst_fetch #(
	parameter int PORT_CREDITS = 2
) (
	input  wire                              raw_clk,
	input  wire                              rst_n,
	input  wire                              boot_done,
	input  wire                              hold,
	input  wire                              set_pc,
	input  wire [mem_pkg::DATA_W-1:0]        set_pc_addr,
	input  wire                              credit,
	input  wire                              rvalid,
	input  wire [mem_pkg::DATA_W-1:0]        rdata,
	output logic                             req,
	output logic [mem_pkg::ADDR_W-1:0]       addr,
	output logic                             inst_valid,
	output logic [mem_pkg::DATA_W-1:0]       inst,
	output logic [mem_pkg::DATA_W-1:0]       inst_pc
);

	// Room for queued reads plus the ones past the grant
	localparam int TAG_DEPTH = PORT_CREDITS + 2;
	localparam int TAG_PW = $clog2(TAG_DEPTH);
	localparam int CNT_W = $clog2(TAG_DEPTH + 1);

	logic [mem_pkg::DATA_W-1:0] pc;
	logic [CNT_W-1:0]           credits;
	logic [mem_pkg::DATA_W-1:0] tag_pc [TAG_DEPTH];
	logic [TAG_PW-1:0]          tag_wr;
	logic [TAG_PW-1:0]          tag_rd;
	logic [CNT_W-1:0]           in_flight;
	logic [CNT_W-1:0]           drop_cnt;
	logic                       issue;
	logic                       stale;

	assign issue = boot_done && !hold && !set_pc && (credits != '0) &&
		(in_flight != CNT_W'(TAG_DEPTH));
	assign stale = (drop_cnt != '0);

	always_ff @(posedge raw_clk) begin
		if (!rst_n) begin
			pc <= '0;
			credits <= CNT_W'(PORT_CREDITS);
			tag_wr <= '0;
			tag_rd <= '0;
			in_flight <= '0;
			drop_cnt <= '0;
			req <= 1'b0;
			inst_valid <= 1'b0;
		end else begin
			req <= issue;
			credits <= credits - CNT_W'(issue) + CNT_W'(credit);
			in_flight <= in_flight + CNT_W'(issue) - CNT_W'(rvalid);
			if (issue) begin
				pc <= pc + 1'b1;
				tag_wr <= (tag_wr == TAG_PW'(TAG_DEPTH - 1)) ? '0 : tag_wr + 1'b1;
			end
			if (rvalid)
				tag_rd <= (tag_rd == TAG_PW'(TAG_DEPTH - 1)) ? '0 : tag_rd + 1'b1;
			// Everything still in flight belongs to the old stream
			if (set_pc) begin
				pc <= set_pc_addr;
				drop_cnt <= in_flight - CNT_W'(rvalid);
			end else if (rvalid && stale) begin
				drop_cnt <= drop_cnt - 1'b1;
			end
			inst_valid <= rvalid && !stale && !set_pc;
		end
	end

	always_ff @(posedge raw_clk) begin
		if (issue) begin
			tag_pc[tag_wr] <= pc;
			addr <= {{(mem_pkg::ADDR_W - mem_pkg::DATA_W){1'b0}}, pc};
		end
		if (rvalid) begin
			inst <= rdata;
			inst_pc <= tag_pc[tag_rd];
		end
	end

endmodule

`default_nettype wire

//--- source/mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys #(
	parameter int PORT_CREDITS = 2
) (
	input  wire                              raw_clk,
	input  wire                              rst_n,
	output wire [boot_pkg::FLASH_AW-1:0]     flash_addr,
	output wire                              flash_rd,
	input  wire                              flash_ready,
	input  wire [mem_pkg::DATA_W-1:0]        flash_rdata,
	output wire [mem_pkg::ADDR_W-1:0]        ram_addr,
	output wire [mem_pkg::DATA_W-1:0]        ram_wdata,
	output wire                              ram_en,
	output wire                              ram_oe,
	output wire                              ram_we,
	input  wire [mem_pkg::DATA_W-1:0]        ram_rdata,
	input  wire                              exe_req,
	input  wire mem_pkg::mem_op_e            exe_op,
	input  wire [mem_pkg::ADDR_W-1:0]        exe_addr,
	input  wire [mem_pkg::DATA_W-1:0]        exe_wdata,
	output wire                              exe_credit,
	output wire                              exe_rvalid,
	output wire [mem_pkg::DATA_W-1:0]        exe_rdata,
	input  wire                              hold,
	input  wire                              set_pc,
	input  wire [mem_pkg::DATA_W-1:0]        set_pc_addr,
	output wire                              inst_valid,
	output wire [mem_pkg::DATA_W-1:0]        inst,
	output wire [mem_pkg::DATA_W-1:0]        inst_pc,
	output wire                              boot_done
);

	// Bootloader port
	wire                              boot_req;
	wire mem_pkg::mem_op_e            boot_op;
	wire [mem_pkg::ADDR_W-1:0]        boot_addr;
	wire [mem_pkg::DATA_W-1:0]        boot_wdata;
	wire                              boot_credit;

	// Fetch port
	wire                              fetch_req;
	wire [mem_pkg::ADDR_W-1:0]        fetch_addr;
	wire                              fetch_credit;
	wire                              fetch_rvalid;
	wire [mem_pkg::DATA_W-1:0]        fetch_rdata;

	// Arbiter to SRAM controller
	wire                              grant_valid;
	wire mem_pkg::mem_op_e            grant_op;
	wire [mem_pkg::ADDR_W-1:0]        grant_addr;
	wire [mem_pkg::DATA_W-1:0]        grant_wdata;
	wire mem_pkg::port_id_e           grant_port;
	wire                              sram_ready;
	wire                              done_valid;
	wire mem_pkg::port_id_e           done_port;
	wire [mem_pkg::DATA_W-1:0]        done_rdata;

	bootloader #(
		.PORT_CREDITS(PORT_CREDITS)
	) u_bootloader (
		.*,
		.credit(boot_credit),
		.req(boot_req),
		.op(boot_op),
		.addr(boot_addr),
		.wdata(boot_wdata)
	);

	inst_fetch #(
		.PORT_CREDITS(PORT_CREDITS)
	) u_inst_fetch (
		.*,
		.credit(fetch_credit),
		.rvalid(fetch_rvalid),
		.rdata(fetch_rdata),
		.req(fetch_req),
		.addr(fetch_addr)
	);

	// Boot only writes, fetch only reads
	ram_arbiter #(
		.PORT_CREDITS(PORT_CREDITS)
	) u_ram_arbiter (
		.*,
		.boot_rvalid(),
		.boot_rdata(),
		.fetch_op(mem_pkg::OP_READ),
		.fetch_wdata('0),
		.ready(sram_ready)
	);

	sram_ctrl u_sram_ctrl (
		.*,
		.ready(sram_ready)
	);

endmodule

`default_nettype wire

//--- tests/mem_subsys_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_asserts #(
	parameter bit ARB_SIDE = 1'b1
) (
	input wire       raw_clk,
	input wire       rst_n,
	input wire       grant_valid,
	input wire       ready,
	input wire [2:0] credit_pulses,
	input wire       ram_oe,
	input wire       ram_we,
	input wire       req_full
);

	if (ARB_SIDE) begin : g_arb
		// One credit pulse per grant, so at most one per cycle
		a_one_grant: assert property (@(posedge raw_clk) disable iff (!rst_n)
			$onehot0(credit_pulses))
			else $error("more than one grant in one cycle");

		a_no_full_req: assert property (@(posedge raw_clk) disable iff (!rst_n)
			!req_full)
			else $error("request arrived at a full arbiter queue");
	end else begin : g_sram
		a_grant_ready: assert property (@(posedge raw_clk) disable iff (!rst_n)
			grant_valid |-> ready)
			else $error("grant while the SRAM controller is busy");

		a_strobes: assert property (@(posedge raw_clk) disable iff (!rst_n)
			!(ram_oe && ram_we))
			else $error("SRAM output enable and write enable high together");
	end

endmodule

bind ram_arbiter mem_subsys_asserts #(
	.ARB_SIDE(1'b1)
) u_arb_asserts (
	.raw_clk(raw_clk),
	.rst_n(rst_n),
	.grant_valid(grant_valid),
	.ready(ready),
	.credit_pulses({boot_credit, exe_credit, fetch_credit}),
	.ram_oe(1'b0),
	.ram_we(1'b0),
	.req_full((boot_req && q_count[0] == PORT_CREDITS) ||
		(exe_req && q_count[1] == PORT_CREDITS) ||
		(fetch_req && q_count[2] == PORT_CREDITS))
);

bind sram_ctrl mem_subsys_asserts #(
	.ARB_SIDE(1'b0)
) u_sram_asserts (
	.raw_clk(raw_clk),
	.rst_n(rst_n),
	.grant_valid(grant_valid),
	.ready(ready),
	.credit_pulses(3'b000),
	.ram_oe(ram_oe),
	.ram_we(ram_we),
	.req_full(1'b0)
);

`default_nettype wire

//--- tests/mem_subsys_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_tb;

	localparam int PORT_CREDITS = 2;

	logic                       raw_clk;
	logic                       rst_n;
	wire [21:0]                 flash_addr;
	wire                        flash_rd;
	logic                       flash_ready;
	logic [15:0]                flash_rdata;
	wire [17:0]                 ram_addr;
	wire [15:0]                 ram_wdata;
	wire                        ram_en;
	wire                        ram_oe;
	wire                        ram_we;
	wire [15:0]                 ram_rdata;
	logic                       exe_req;
	mem_pkg::mem_op_e           exe_op;
	logic [17:0]                exe_addr;
	logic [15:0]                exe_wdata;
	wire                        exe_credit;
	wire                        exe_rvalid;
	wire [15:0]                 exe_rdata;
	logic                       hold;
	logic                       set_pc;
	logic [15:0]                set_pc_addr;
	wire                        inst_valid;
	wire [15:0]                 inst;
	wire [15:0]                 inst_pc;
	wire                        boot_done;

	logic [15:0] sram_mem [0:262143];
	logic [15:0] flash_mem [0:63];
	logic [15:0] ref_mem [int];
	logic [15:0] image [$];
	logic [15:0] exp_q [$];
	logic [7:0]  cmd_q [$];
	logic [31:0] arg1_q [$];
	logic [31:0] arg2_q [$];
	integer      seed = 8807;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_err_start;
	int          cycles = 0;
	int          cycle_limit = 0;
	int          img_len = 0;
	int          exe_credits = PORT_CREDITS;
	int          fetch_count = 0;
	int          hold_extra = 0;
	logic        hold_armed = 0;
	logic        redirect_pending = 0;
	logic [15:0] redirect_target;
	logic [15:0] exp_pc = 0;
	string       cur_test = "startup";

	mem_subsys #(
		.PORT_CREDITS(PORT_CREDITS)
	) dut (.*);

	// SRAM drives its data only while enabled for reading
	assign ram_rdata = (ram_en && ram_oe) ? sram_mem[ram_addr] : 'x;

	// Depends on every address bit
	function automatic logic [15:0] fill_word(input int a);
		return a[15:0] ^ {a[17:16], a[17:16], 12'h000} ^ 16'hc3a5;
	endfunction

	function automatic logic [15:0] ref_word(input int a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return fill_word(a);
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %0t ns: %s: got %h, expected %h",
				$time, msg, actual, expected);
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_err_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == test_err_start) begin
			$display("test %s: passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d error(s)", cur_test, errors - test_err_start);
		end
	endtask

	// Called and returns at 2 ns after a rising edge
	task automatic exe_issue(input mem_pkg::mem_op_e op, input logic [17:0] a,
		input logic [15:0] data, input logic [15:0] expect_data);
		while (exe_credits == 0) begin
			@(posedge raw_clk);
			#2;
		end
		exe_op = op;
		exe_addr = a;
		exe_wdata = data;
		exe_req = 1'b1;
		exe_credits--;
		if (op == mem_pkg::OP_WRITE)
			ref_mem[int'(a)] = data;
		else
			exp_q.push_back(expect_data);
		@(posedge raw_clk);
		#2;
		exe_req = 1'b0;
	endtask

	task automatic wait_reads();
		while (exp_q.size() != 0) begin
			@(posedge raw_clk);
			#2;
		end
	endtask

	initial begin
		raw_clk = 1'b0;
		forever #10 raw_clk = ~raw_clk;
	end

	always @(posedge raw_clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: test %s did not finish within %0d cycles",
				cur_test, cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	// SRAM write strobe
	always @(posedge raw_clk) begin
		if (ram_en && ram_we)
			sram_mem[ram_addr] <= ram_wdata;
	end

	// Flash with a random latency of 1 to 3 cycles
	initial begin
		int lat;
		logic [21:0] fa;
		forever begin
			@(negedge raw_clk);
			if (rst_n && flash_rd) begin
				fa = flash_addr;
				lat = 1 + ($unsigned($random(seed)) % 3);
				repeat (lat) @(posedge raw_clk);
				#2;
				if (fa > 63) begin
					errors++;
					$display("flash read outside the image area at address %h", fa);
				end
				flash_ready = 1'b1;
				flash_rdata = flash_mem[fa[5:0]];
				@(posedge raw_clk);
				#2;
				flash_ready = 1'b0;
			end
		end
	end

	// Execute port credits and responses
	always @(negedge raw_clk) begin
		if (rst_n) begin
			if (exe_credit) begin
				exe_credits++;
				check(exe_credits <= PORT_CREDITS, 1, "execute credit count above limit");
			end
			if (exe_rvalid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("execute port returned read data nobody asked for at %0t ns", $time);
				end else begin
					check(exe_rdata, exp_q.pop_front(), "execute read data");
				end
			end
		end
	end

	// Fetch stream: pcs in sequence, words match memory
	always @(negedge raw_clk) begin
		if (rst_n) begin
			if (inst_valid) begin
				if (redirect_pending)
					check(inst_pc, redirect_target, "first pc after redirect");
				else
					check(inst_pc, exp_pc, "fetch pc out of sequence");
				redirect_pending = 1'b0;
				check(inst, ref_word(int'(inst_pc)), "fetched instruction word");
				exp_pc = inst_pc + 1'b1;
				fetch_count++;
				if (hold_armed)
					hold_extra++;
			end
			if (set_pc) begin
				redirect_pending = 1'b1;
				redirect_target = set_pc_addr;
			end
			hold_armed = hold;
		end
	end

	initial begin
		int fd;
		int rc;
		int cnt;
		string line;
		logic [7:0] cmd;
		logic [31:0] a1;
		logic [31:0] a2;

		rst_n = 1'b0;
		flash_ready = 1'b0;
		flash_rdata = '0;
		exe_req = 1'b0;
		exe_op = mem_pkg::OP_READ;
		exe_addr = '0;
		exe_wdata = '0;
		hold = 1'b0;
		set_pc = 1'b0;
		set_pc_addr = '0;

		fd = $fopen("tests/mem_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open the stimulus file tests/mem_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				a2 = '0;
				if (rc > 0 && line.len() > 1 && line[0] != "#") begin
					rc = $sscanf(line, "%c %h %h", cmd, a1, a2);
					if (cmd == "L") begin
						img_len = a1;
					end else if (cmd == "I") begin
						image.push_back(a1[15:0]);
					end else begin
						cmd_q.push_back(cmd);
						arg1_q.push_back(a1);
						arg2_q.push_back(a2);
					end
				end
			end
			$fclose(fd);
		end
		if (image.size() != img_len) begin
			errors++;
			$display("image length %0d does not match %0d image words", img_len, image.size());
		end

		for (int a = 0; a < 262144; a++)
			sram_mem[a] = fill_word(a);
		for (int a = 0; a < 64; a++)
			flash_mem[a] = fill_word(a + 'h30000);
		flash_mem[0] = img_len[15:0];
		foreach (image[i]) begin
			flash_mem[i + 1] = image[i];
			ref_mem[i] = image[i];
		end
		cycle_limit = (img_len + cmd_q.size()) * 40 + 500;

		repeat (4) @(posedge raw_clk);
		#2;
		rst_n = 1'b1;

		start_test("boot copy");
		while (!boot_done) begin
			@(posedge raw_clk);
			#2;
		end
		foreach (image[i])
			exe_issue(mem_pkg::OP_READ, i, '0, image[i]);
		wait_reads();
		foreach (image[i])
			check(sram_mem[i], image[i], "SRAM model word after boot");
		end_test();

		start_test("sequential fetch");
		while (fetch_count < img_len) begin
			@(posedge raw_clk);
			#2;
		end
		end_test();

		foreach (cmd_q[c]) begin
			a1 = arg1_q[c];
			a2 = arg2_q[c];
			case (cmd_q[c])
				"W": begin
					start_test($sformatf("execute write %h", a1));
					exe_issue(mem_pkg::OP_WRITE, a1[17:0], a2[15:0], '0);
				end
				"R": begin
					start_test($sformatf("execute read %h", a1));
					exe_issue(mem_pkg::OP_READ, a1[17:0], '0, a2[15:0]);
					wait_reads();
				end
				"B": begin
					start_test($sformatf("credit burst at %h", a1));
					for (int k = 0; k < a2; k++)
						exe_issue(mem_pkg::OP_WRITE, a1[17:0] + k, 16'hb000 + k, '0);
					for (int k = 0; k < a2; k++)
						exe_issue(mem_pkg::OP_READ, a1[17:0] + k, '0, 16'hb000 + k);
					wait_reads();
					check(exe_credits, PORT_CREDITS, "execute credits back after burst");
				end
				"J": begin
					start_test($sformatf("redirect to %h", a1));
					set_pc = 1'b1;
					set_pc_addr = a1[15:0];
					@(posedge raw_clk);
					#2;
					set_pc = 1'b0;
					while (redirect_pending) begin
						@(posedge raw_clk);
						#2;
					end
				end
				"H": begin
					start_test($sformatf("hold for %0d cycles", a1));
					hold_extra = 0;
					hold = 1'b1;
					repeat (a1) @(posedge raw_clk);
					#2;
					hold = 1'b0;
					// Queued reads plus the one inside the SRAM controller
					check(hold_extra <= PORT_CREDITS + 1, 1, "fetches delivered during hold");
					cnt = fetch_count;
					while (fetch_count == cnt) begin
						@(posedge raw_clk);
						#2;
					end
				end
				default: begin
					start_test("unknown command");
					errors++;
					$display("stimulus command %c is not known", cmd_q[c]);
				end
			endcase
			end_test();
		end

		start_test("idle credits");
		wait_reads();
		repeat (4) @(posedge raw_clk);
		#2;
		check(exe_credits, PORT_CREDITS, "execute credits at idle");
		end_test();

		$display("tests: %0d run, %0d passed, %0d failed, %0d error(s)",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/mem_stimulus.txt
# L <image length>, then one I <word> line per image word, all hex
# W addr data | R addr expected | B addr count | J target pc | H hold cycles
L 8
I 1a2b
I 3c4d
I 5e6f
I 7081
I 92a3
I b4c5
I d6e7
I f809
W 2000 beef
R 2000 beef
R 0003 7081
B 2100 4
J 0004
H 14
J 0002

//--- src.f
source/mem_pkg.sv
source/boot_pkg.sv
source/sram_ctrl.sv
source/ram_arbiter.sv
source/bootloader.sv
source/inst_fetch.sv
source/mem_subsys.sv
tests/mem_subsys_asserts.sv
tests/mem_subsys_tb.sv
